// ==== alu.sv ====
module alu (
    input  logic [mips_exec_pkg::NB_DATA-1:0] i_data_a,
    input  logic [mips_exec_pkg::NB_DATA-1:0] i_data_b,
    input  mips_exec_pkg::alu_funct_e         i_funct,
    output logic [mips_exec_pkg::NB_DATA-1:0] o_result,
    output logic                              o_zero_bit
);

    import mips_exec_pkg::*;

    // ----------------------------------------
    // Function decode
    // ----------------------------------------
    always_comb begin
        case (i_funct)
            // Arithmetic
            FN_ADD:  o_result = $signed(i_data_a) + $signed(i_data_b);
            FN_ADDU: o_result = i_data_a + i_data_b;
            FN_SUBU: o_result = $signed(i_data_a) - $signed(i_data_b);

            // Logic
            FN_AND:  o_result = i_data_a & i_data_b;
            FN_OR:   o_result = i_data_a | i_data_b;
            FN_XOR:  o_result = i_data_a ^ i_data_b;
            FN_NOR:  o_result = ~(i_data_a | i_data_b);
            FN_SLT:  o_result = ($signed(i_data_a) < $signed(i_data_b)) ?
                                NB_DATA'(1) : NB_DATA'(0);

            // Shifts, A carries shamt or rs depending on the code
            FN_SLL:  o_result = i_data_b << i_data_a;
            FN_SRL:  o_result = i_data_b >> i_data_a;
            FN_SRA:  o_result = $signed(i_data_b) >>> i_data_a;
            FN_SLLV: o_result = i_data_b << i_data_a;
            FN_SRLV: o_result = i_data_b >> i_data_a;
            FN_SRAV: o_result = $signed(i_data_b) >>> i_data_a;

            FN_LUI:  o_result = {i_data_b[15:0], 16'b0};  // Low half of B moved up

            default: o_result = '1;                       // Unknown code
        endcase
    end

    assign o_zero_bit = ~|o_result;

endmodule

// ==== exec_fsm.sv ====
module exec_fsm (
    input  logic                                  i_clk,
    input  logic                                  i_rst_n,
    input  logic                                  i_start,
    input  logic [mips_exec_pkg::NB_DATA-1:0]     i_instr,
    input  logic                                  i_pc_last,
    input  logic [mips_exec_pkg::NB_DATA-1:0]     i_alu_result,
    input  logic                                  i_alu_zero,
    output logic                                  o_pc_clear,
    output logic                                  o_pc_inc,
    output logic                                  o_fetch_en,
    output logic [mips_exec_pkg::NB_REG_ADDR-1:0] o_rs_addr,
    output logic [mips_exec_pkg::NB_REG_ADDR-1:0] o_rt_addr,
    output mips_exec_pkg::alu_funct_e             o_funct,
    output logic                                  o_shamt_sel,
    output logic [mips_exec_pkg::NB_SHAMT-1:0]    o_shamt,
    output logic                                  o_we,
    output logic [mips_exec_pkg::NB_REG_ADDR-1:0] o_wr_addr,
    output logic [mips_exec_pkg::NB_DATA-1:0]     o_wr_data,
    output logic                                  o_busy,
    output logic                                  o_done,
    output logic                                  o_illegal,
    output logic                                  o_zero
);

    import mips_exec_pkg::*;

    exec_state_e        state;
    exec_state_e        state_next;
    opcode_e            opcode;
    logic [NB_DATA-1:0] result_q;

    // ----------------------------------------
    // Instruction fields
    // ----------------------------------------
    assign opcode    = opcode_e'(i_instr[NB_DATA-1 -: NB_OPCODE]);
    assign o_rs_addr = i_instr[25 -: NB_REG_ADDR];
    assign o_rt_addr = i_instr[20 -: NB_REG_ADDR];
    assign o_wr_addr = i_instr[15 -: NB_REG_ADDR];  // rd
    assign o_shamt   = i_instr[10 -: NB_SHAMT];
    assign o_funct   = alu_funct_e'(i_instr[NB_FUNCT-1:0]);

    // Fixed shifts take shamt as A
    assign o_shamt_sel = (o_funct == FN_SLL) || (o_funct == FN_SRL) || (o_funct == FN_SRA);

    // ----------------------------------------
    // State sequence
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) state <= S_IDLE;
        else          state <= state_next;
    end

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE:  if (i_start) state_next = S_FETCH;
            S_FETCH: state_next = S_EXEC;
            S_EXEC:  state_next = (opcode == OP_RTYPE) ? S_WRITE : S_STOP;  // HALT or illegal
            S_WRITE: state_next = i_pc_last ? S_STOP : S_FETCH;
            S_STOP:  state_next = S_IDLE;
            default: state_next = S_IDLE;
        endcase
    end

    assign o_pc_clear = (state == S_IDLE) && i_start;
    assign o_fetch_en = (state == S_FETCH);
    assign o_pc_inc   = (state == S_WRITE);
    assign o_we       = (state == S_WRITE) && (o_wr_addr != '0);
    assign o_wr_data  = result_q;
    assign o_busy     = (state != S_IDLE);

    // Result captured at the end of S_EXEC
    always_ff @(posedge i_clk) begin
        if (state == S_EXEC) result_q <= i_alu_result;
    end

    // ----------------------------------------
    // Sticky status, cleared by a new start
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_done    <= 1'b0;
            o_illegal <= 1'b0;
            o_zero    <= 1'b0;
        end else if (o_pc_clear) begin
            o_done    <= 1'b0;
            o_illegal <= 1'b0;
            o_zero    <= 1'b0;
        end else if (state == S_EXEC) begin
            if (opcode == OP_RTYPE)     o_zero    <= i_alu_zero;
            else if (opcode != OP_HALT) o_illegal <= 1'b1;
        end else if (state == S_STOP) begin
            o_done <= 1'b1;  // Rises as busy falls
        end
    end

endmodule

// ==== filelist.f ====
mips_exec_pkg.sv
alu.sv
reg_file.sv
instr_mem.sv
pc_counter.sv
exec_fsm.sv
wb_host_port.sv
r_exec_top.sv
tb_checker.sv
tb_r_exec.sv

// ==== instr_mem.sv ====
module instr_mem (
    input  logic                              i_clk,
    input  logic                              i_fetch_en,
    input  logic [mips_exec_pkg::NB_PC-1:0]   i_pc,
    output logic [mips_exec_pkg::NB_DATA-1:0] o_instr,
    input  logic [mips_exec_pkg::NB_PC-1:0]   i_host_addr,
    input  logic                              i_host_we,
    input  logic [mips_exec_pkg::NB_DATA-1:0] i_host_wr_data,
    output logic [mips_exec_pkg::NB_DATA-1:0] o_host_data
);

    import mips_exec_pkg::*;

    logic [NB_DATA-1:0] mem [IMEM_DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_host_we) mem[i_host_addr] <= i_host_wr_data;
        if (i_fetch_en) o_instr <= mem[i_pc];  // Held until the next fetch
    end

    assign o_host_data = mem[i_host_addr];     // Host side read

endmodule

// ==== mips_exec_pkg.sv ====
package mips_exec_pkg;

    // ----------------------------------------
    // Field and datapath widths
    // ----------------------------------------
    localparam int NB_DATA     = 32;
    localparam int NB_REG_ADDR = 5;
    localparam int NB_FUNCT    = 6;
    localparam int NB_OPCODE   = 6;
    localparam int NB_SHAMT    = 5;
    localparam int IMEM_DEPTH  = 16;
    localparam int NB_PC       = 4;
    localparam int NB_STEP     = 5;    // Counts up to 16 executed words

    // ----------------------------------------
    // Wishbone word address map
    // ----------------------------------------
    localparam int NB_WB_ADR = 8;
    localparam logic [NB_WB_ADR-1:0] WB_IMEM_BASE  = 8'h00;  // 0x00..0x0F
    localparam logic [NB_WB_ADR-1:0] WB_REG_BASE   = 8'h20;  // 0x20..0x3F
    localparam logic [NB_WB_ADR-1:0] WB_CTRL_ADR   = 8'h40;  // Bit 0 starts a run
    localparam logic [NB_WB_ADR-1:0] WB_STATUS_ADR = 8'h41;

    // Status word layout
    localparam int STAT_BUSY     = 0;
    localparam int STAT_DONE     = 1;
    localparam int STAT_ILLEGAL  = 2;
    localparam int STAT_ZERO     = 3;
    localparam int STAT_STEP_LSB = 8;

    typedef enum logic [NB_FUNCT-1:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_LUI  = 6'b101011
    } alu_funct_e;

    typedef enum logic [NB_OPCODE-1:0] {
        OP_RTYPE = 6'b000000,
        OP_HALT  = 6'b111111
    } opcode_e;

    typedef enum logic [2:0] {S_IDLE, S_FETCH, S_EXEC, S_WRITE, S_STOP} exec_state_e;

endpackage

// ==== pc_counter.sv ====
module pc_counter (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_clear,
    input  logic                              i_inc,
    output logic [mips_exec_pkg::NB_PC-1:0]   o_pc,
    output logic [mips_exec_pkg::NB_STEP-1:0] o_step,
    output logic                              o_last
);

    import mips_exec_pkg::*;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc   <= '0;
            o_step <= '0;
        end else if (i_clear) begin
            o_pc   <= '0;
            o_step <= '0;
        end else if (i_inc) begin
            o_pc   <= o_pc + 1'b1;
            o_step <= o_step + 1'b1;  // One extra bit so 16 steps fit
        end
    end

    // Final word of the memory, the FSM stops here instead of wrapping
    assign o_last = (o_pc == NB_PC'(IMEM_DEPTH - 1));

endmodule

// ==== r_exec_top.sv ====
module r_exec_top (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_wb_cyc,
    input  logic                                i_wb_stb,
    input  logic                                i_wb_we,
    input  logic [mips_exec_pkg::NB_WB_ADR-1:0] i_wb_adr,
    input  logic [mips_exec_pkg::NB_DATA-1:0]   i_wb_dat,
    output logic                                o_wb_ack,
    output logic [mips_exec_pkg::NB_DATA-1:0]   o_wb_dat,
    output logic                                o_done
);

    import mips_exec_pkg::*;

    // Host side
    logic [NB_REG_ADDR-1:0] host_addr;
    logic                   imem_we;
    logic                   reg_we;
    logic [NB_DATA-1:0]     host_wr_data;
    logic                   start;
    logic [NB_DATA-1:0]     imem_host_data;
    logic [NB_DATA-1:0]     reg_host_data;

    // Engine side
    logic                   busy;
    logic                   illegal;
    logic                   zero;
    logic [NB_STEP-1:0]     step;
    logic [NB_PC-1:0]       pc;
    logic                   pc_last;
    logic                   pc_clear;
    logic                   pc_inc;
    logic                   fetch_en;
    logic [NB_DATA-1:0]     instr;
    logic [NB_REG_ADDR-1:0] rs_addr;
    logic [NB_REG_ADDR-1:0] rt_addr;
    alu_funct_e             funct;
    logic                   shamt_sel;
    logic [NB_SHAMT-1:0]    shamt;
    logic                   we;
    logic [NB_REG_ADDR-1:0] wr_addr;
    logic [NB_DATA-1:0]     wr_data;
    logic [NB_DATA-1:0]     rs_data;
    logic [NB_DATA-1:0]     rt_data;
    logic [NB_DATA-1:0]     alu_a;
    logic [NB_DATA-1:0]     alu_result;
    logic                   alu_zero;

    assign alu_a = shamt_sel ? NB_DATA'(shamt) : rs_data;  // Shamt or rs as operand A

    wb_host_port u_wb_host_port (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_wb_cyc       (i_wb_cyc),
        .i_wb_stb       (i_wb_stb),
        .i_wb_we        (i_wb_we),
        .i_wb_adr       (i_wb_adr),
        .i_wb_dat       (i_wb_dat),
        .o_wb_ack       (o_wb_ack),
        .o_wb_dat       (o_wb_dat),
        .i_busy         (busy),
        .i_done         (o_done),
        .i_illegal      (illegal),
        .i_zero         (zero),
        .i_step         (step),
        .i_imem_data    (imem_host_data),
        .i_reg_data     (reg_host_data),
        .o_host_addr    (host_addr),
        .o_imem_we      (imem_we),
        .o_reg_we       (reg_we),
        .o_host_wr_data (host_wr_data),
        .o_start        (start)
    );

    exec_fsm u_exec_fsm (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (start),
        .i_instr      (instr),
        .i_pc_last    (pc_last),
        .i_alu_result (alu_result),
        .i_alu_zero   (alu_zero),
        .o_pc_clear   (pc_clear),
        .o_pc_inc     (pc_inc),
        .o_fetch_en   (fetch_en),
        .o_rs_addr    (rs_addr),
        .o_rt_addr    (rt_addr),
        .o_funct      (funct),
        .o_shamt_sel  (shamt_sel),
        .o_shamt      (shamt),
        .o_we         (we),
        .o_wr_addr    (wr_addr),
        .o_wr_data    (wr_data),
        .o_busy       (busy),
        .o_done       (o_done),
        .o_illegal    (illegal),
        .o_zero       (zero)
    );

    pc_counter u_pc_counter (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_clear (pc_clear),
        .i_inc   (pc_inc),
        .o_pc    (pc),
        .o_step  (step),
        .o_last  (pc_last)
    );

    instr_mem u_instr_mem (
        .i_clk          (i_clk),
        .i_fetch_en     (fetch_en),
        .i_pc           (pc),
        .o_instr        (instr),
        .i_host_addr    (host_addr[NB_PC-1:0]),
        .i_host_we      (imem_we),
        .i_host_wr_data (host_wr_data),
        .o_host_data    (imem_host_data)
    );

    reg_file u_reg_file (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_rs_addr      (rs_addr),
        .i_rt_addr      (rt_addr),
        .i_host_addr    (host_addr),
        .o_rs_data      (rs_data),
        .o_rt_data      (rt_data),
        .o_host_data    (reg_host_data),
        .i_we           (we),
        .i_wr_addr      (wr_addr),
        .i_wr_data      (wr_data),
        .i_host_we      (reg_we),
        .i_host_wr_data (host_wr_data)
    );

    alu u_alu (
        .i_data_a   (alu_a),
        .i_data_b   (rt_data),
        .i_funct    (funct),
        .o_result   (alu_result),
        .o_zero_bit (alu_zero)
    );

endmodule

// ==== reg_file.sv ====
module reg_file (
    input  logic                                  i_clk,
    input  logic                                  i_rst_n,
    input  logic [mips_exec_pkg::NB_REG_ADDR-1:0] i_rs_addr,
    input  logic [mips_exec_pkg::NB_REG_ADDR-1:0] i_rt_addr,
    input  logic [mips_exec_pkg::NB_REG_ADDR-1:0] i_host_addr,
    output logic [mips_exec_pkg::NB_DATA-1:0]     o_rs_data,
    output logic [mips_exec_pkg::NB_DATA-1:0]     o_rt_data,
    output logic [mips_exec_pkg::NB_DATA-1:0]     o_host_data,
    input  logic                                  i_we,
    input  logic [mips_exec_pkg::NB_REG_ADDR-1:0] i_wr_addr,
    input  logic [mips_exec_pkg::NB_DATA-1:0]     i_wr_data,
    input  logic                                  i_host_we,
    input  logic [mips_exec_pkg::NB_DATA-1:0]     i_host_wr_data
);

    import mips_exec_pkg::*;

    logic [NB_DATA-1:0] regs [2**NB_REG_ADDR];

    // Engine write wins, r0 never changes
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**NB_REG_ADDR; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            if (i_wr_addr != '0) regs[i_wr_addr] <= i_wr_data;
        end else if (i_host_we) begin
            if (i_host_addr != '0) regs[i_host_addr] <= i_host_wr_data;
        end
    end

    assign o_rs_data   = regs[i_rs_addr];
    assign o_rt_data   = regs[i_rt_addr];
    assign o_host_data = regs[i_host_addr];

endmodule

// ==== tb_checker.sv ====
module tb_checker (
    input logic                              i_clk,
    input logic                              i_wb_ack,
    input logic [mips_exec_pkg::NB_DATA-1:0] i_wb_dat,
    input logic                              i_done
);

    timeunit 1ns;
    timeprecision 1ps;

    import mips_exec_pkg::*;

    string              test_name;
    logic [NB_DATA-1:0] expected;
    logic               armed = 1'b0;
    logic               done_q = 1'b0;
    int                 n_pass = 0;
    int                 n_fail = 0;
    int                 n_runs = 0;

    // Next acknowledged read is compared against this value
    task automatic expect_value(input string name, input logic [NB_DATA-1:0] value);
        test_name = name;
        expected  = value;
        armed     = 1'b1;
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        n_fail++;
    endtask

    // ----------------------------------------
    // Read data is valid while ack is high
    // ----------------------------------------
    always @(posedge i_clk) begin
        if (i_wb_ack && armed) begin
            armed = 1'b0;
            if (i_wb_dat === expected) begin
                $display("[PASS]  %s = 0x%08h", test_name, i_wb_dat);
                n_pass++;
            end else begin
                $display("[ERROR] %s expected 0x%08h actual 0x%08h",
                         test_name, expected, i_wb_dat);
                n_fail++;
            end
        end
        if (i_done && !done_q) n_runs++;  // Rising done ends a run
        done_q = i_done;
    end

    task automatic print_summary();
        $display("Checks passed %0d, failed %0d, runs finished %0d", n_pass, n_fail, n_runs);
    endtask

endmodule

// ==== tb_r_exec.sv ====
module tb_r_exec;

    timeunit 1ns;
    timeprecision 1ps;

    import mips_exec_pkg::*;

    typedef struct {
        logic [NB_FUNCT-1:0] funct;
        logic [NB_DATA-1:0]  a;
        logic [NB_DATA-1:0]  b;
        logic [NB_SHAMT-1:0] shamt;
        logic [NB_DATA-1:0]  result;
    } alu_row_t;

    localparam logic [NB_DATA-1:0] HALT_WORD = {OP_HALT, 26'b0};

    logic                 clk;
    logic                 rst_n;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [NB_WB_ADR-1:0] wb_adr;
    logic [NB_DATA-1:0]   wb_dat_w;
    logic                 wb_ack;
    logic [NB_DATA-1:0]   wb_dat_r;
    logic                 done;
    logic [NB_DATA-1:0]   ra;
    logic [NB_DATA-1:0]   rb;
    alu_row_t             rows [20];
    int                   seed = 35;

    r_exec_top dut0 (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat_w),
        .o_wb_ack (wb_ack),
        .o_wb_dat (wb_dat_r),
        .o_done   (done)
    );

    tb_checker chk0 (
        .i_clk    (clk),
        .i_wb_ack (wb_ack),
        .i_wb_dat (wb_dat_r),
        .i_done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // MIPS R-type word with major opcode 0
    function automatic logic [NB_DATA-1:0] rtype(input logic [5:0] fn, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [4:0] rd,
                                                 input logic [4:0] sh);
        return {6'b0, rs, rt, rd, sh, fn};
    endfunction

    // ----------------------------------------
    // Wishbone driver
    // ----------------------------------------
    task automatic bus_access(input logic we, input logic [NB_WB_ADR-1:0] adr,
                              input logic [NB_DATA-1:0] dat);
        int n;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!wb_ack && n < 10);
        if (!wb_ack) chk0.report_failure($sformatf("No ack for access to address 0x%02h", adr));
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic reg_write(input int idx, input logic [NB_DATA-1:0] value);
        bus_access(1'b1, WB_REG_BASE + NB_WB_ADR'(idx), value);
    endtask

    task automatic imem_write(input int idx, input logic [NB_DATA-1:0] word);
        bus_access(1'b1, WB_IMEM_BASE + NB_WB_ADR'(idx), word);
    endtask

    task automatic read_check(input string name, input logic [NB_WB_ADR-1:0] adr,
                              input logic [NB_DATA-1:0] value);
        chk0.expect_value(name, value);
        bus_access(1'b0, adr, '0);
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!done && n < 200);
        if (!done) chk0.report_failure("Run never reached done within 200 cycles");
    endtask

    // r3 = op(r1, r2) followed by HALT
    task automatic run_single(input alu_row_t row);
        reg_write(1, row.a);
        reg_write(2, row.b);
        imem_write(0, rtype(row.funct, 5'd1, 5'd2, 5'd3, row.shamt));
        imem_write(1, HALT_WORD);
        bus_access(1'b1, WB_CTRL_ADR, 32'h1);
        wait_done();
    endtask

    initial begin
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        rows[0]  = '{FN_ADD,  32'd7,         32'hFFFF_FFFD, 5'd0,  32'd4};
        rows[1]  = '{FN_ADDU, 32'hFFFF_FFFF, 32'd2,         5'd0,  32'd1};
        rows[2]  = '{FN_SUBU, 32'd10,        32'd3,         5'd0,  32'd7};
        rows[3]  = '{FN_AND,  32'hF0F0_F0F0, 32'hFF00_FF00, 5'd0,  32'hF000_F000};
        rows[4]  = '{FN_OR,   32'hF0F0_0000, 32'h0000_0F0F, 5'd0,  32'hF0F0_0F0F};
        rows[5]  = '{FN_XOR,  32'hFFFF_0000, 32'hFF00_FF00, 5'd0,  32'h00FF_FF00};
        rows[6]  = '{FN_NOR,  32'hF0F0_F0F0, 32'h0F0F_0000, 5'd0,  32'h0000_0F0F};
        rows[7]  = '{FN_SLT,  32'hFFFF_FFFF, 32'd1,         5'd0,  32'd1};
        rows[8]  = '{FN_SLL,  32'h0000_1234, 32'd1,         5'd4,  32'd16};   // rs ignored
        rows[9]  = '{FN_SRL,  32'd0,         32'h8000_0000, 5'd31, 32'd1};
        rows[10] = '{FN_SRA,  32'd0,         32'h8000_0000, 5'd4,  32'hF800_0000};
        rows[11] = '{FN_SLLV, 32'd3,         32'd5,         5'd0,  32'd40};
        rows[12] = '{FN_SRLV, 32'd4,         32'hF000_0000, 5'd0,  32'h0F00_0000};
        rows[13] = '{FN_SRAV, 32'd8,         32'h8000_0000, 5'd0,  32'hFF80_0000};
        rows[14] = '{FN_LUI,  32'd0,         32'h0001_ABCD, 5'd0,  32'hABCD_0000};
        rows[15] = '{6'h3E,   32'd1,         32'd2,         5'd0,  32'hFFFF_FFFF};
        for (int k = 16; k < 20; k++) begin
            ra = $random(seed);
            rb = $random(seed);
            if (k % 2 == 0) rows[k] = '{FN_ADDU, ra, rb, 5'd0, ra + rb};
            else            rows[k] = '{FN_XOR, ra, rb, 5'd0, ra ^ rb};
        end

        for (int i = 0; i < 20; i++) begin
            run_single(rows[i]);
            read_check($sformatf("alu row %0d funct 0x%02h", i, rows[i].funct),
                       WB_REG_BASE + 8'd3, rows[i].result);
        end

        // Zero flag set by an equal subtract then cleared
        run_single('{FN_SUBU, 32'h55, 32'h55, 5'd0, 32'd0});
        read_check("zero flag set", WB_STATUS_ADR, 32'h0000_010A);
        run_single('{FN_SUBU, 32'h55, 32'h54, 5'd0, 32'd1});
        read_check("zero flag clear", WB_STATUS_ADR, 32'h0000_0102);

        // ----------------------------------------
        // Chained program and a rerun under host writes
        // ----------------------------------------
        reg_write(1, 32'd5);
        reg_write(2, 32'd3);
        reg_write(9, 32'h9999);
        imem_write(0, rtype(FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0));  // r3 = 8
        imem_write(1, rtype(FN_SLLV, 5'd2, 5'd3, 5'd4, 5'd0));  // r4 = 64
        imem_write(2, rtype(FN_SUBU, 5'd4, 5'd1, 5'd5, 5'd0));  // r5 = 59
        imem_write(3, rtype(FN_XOR, 5'd5, 5'd3, 5'd6, 5'd0));   // r6 = 51
        imem_write(4, HALT_WORD);
        bus_access(1'b1, WB_CTRL_ADR, 32'h1);
        wait_done();
        read_check("chain r3", WB_REG_BASE + 8'd3, 32'd8);
        read_check("chain r4", WB_REG_BASE + 8'd4, 32'd64);
        read_check("chain r5", WB_REG_BASE + 8'd5, 32'd59);
        read_check("chain r6", WB_REG_BASE + 8'd6, 32'd51);
        read_check("chain status", WB_STATUS_ADR, 32'h0000_0402);
        for (int i = 0; i < 4; i++) begin
            imem_write(i, rtype(FN_ADDU, 5'd3, 5'd1, 5'd3, 5'd0));  // r3 += r1
        end
        bus_access(1'b1, WB_CTRL_ADR, 32'h1);
        reg_write(9, 32'h1234);                 // Dropped while the engine runs
        bus_access(1'b1, WB_CTRL_ADR, 32'h1);   // Restart ignored
        wait_done();
        read_check("busy write dropped r9", WB_REG_BASE + 8'd9, 32'h9999);
        read_check("busy restart r3", WB_REG_BASE + 8'd3, 32'd28);  // 8 plus four adds of 5
        read_check("busy restart status", WB_STATUS_ADR, 32'h0000_0402);

        // Illegal opcode after one instruction
        reg_write(1, 32'h10);
        reg_write(2, 32'h20);
        reg_write(8, 32'hDEAD);
        imem_write(0, rtype(FN_ADDU, 5'd1, 5'd2, 5'd7, 5'd0));
        imem_write(1, {6'h05, 5'd1, 5'd2, 5'd8, 5'd0, 6'(FN_ADDU)});
        bus_access(1'b1, WB_CTRL_ADR, 32'h1);
        wait_done();
        read_check("illegal status", WB_STATUS_ADR, 32'h0000_0106);
        read_check("illegal r7", WB_REG_BASE + 8'd7, 32'h30);
        read_check("illegal rd kept", WB_REG_BASE + 8'd8, 32'hDEAD);

        // Full memory without HALT where word 5 targets r0
        reg_write(10, 32'd0);
        reg_write(11, 32'd1);
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            if (i == 5) imem_write(i, rtype(FN_ADDU, 5'd11, 5'd11, 5'd0, 5'd0));
            else        imem_write(i, rtype(FN_ADDU, 5'd10, 5'd11, 5'd10, 5'd0));
        end
        bus_access(1'b1, WB_CTRL_ADR, 32'h1);
        wait_done();
        read_check("end of memory status", WB_STATUS_ADR, 32'h0000_1002);
        read_check("end of memory r10", WB_REG_BASE + 8'd10, 32'd15);
        read_check("r0 stays zero", WB_REG_BASE, 32'd0);

        chk0.print_summary();
        if (chk0.n_fail == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== wb_host_port.sv ====
module wb_host_port (
    input  logic                                  i_clk,
    input  logic                                  i_rst_n,
    input  logic                                  i_wb_cyc,
    input  logic                                  i_wb_stb,
    input  logic                                  i_wb_we,
    input  logic [mips_exec_pkg::NB_WB_ADR-1:0]   i_wb_adr,
    input  logic [mips_exec_pkg::NB_DATA-1:0]     i_wb_dat,
    output logic                                  o_wb_ack,
    output logic [mips_exec_pkg::NB_DATA-1:0]     o_wb_dat,
    input  logic                                  i_busy,
    input  logic                                  i_done,
    input  logic                                  i_illegal,
    input  logic                                  i_zero,
    input  logic [mips_exec_pkg::NB_STEP-1:0]     i_step,
    input  logic [mips_exec_pkg::NB_DATA-1:0]     i_imem_data,
    input  logic [mips_exec_pkg::NB_DATA-1:0]     i_reg_data,
    output logic [mips_exec_pkg::NB_REG_ADDR-1:0] o_host_addr,
    output logic                                  o_imem_we,
    output logic                                  o_reg_we,
    output logic [mips_exec_pkg::NB_DATA-1:0]     o_host_wr_data,
    output logic                                  o_start
);

    import mips_exec_pkg::*;

    logic                 req;
    logic                 we_q;
    logic [NB_WB_ADR-1:0] adr_q;
    logic [NB_DATA-1:0]   dat_q;
    logic                 imem_hit;
    logic                 reg_hit;
    logic                 wr_ok;
    logic [NB_DATA-1:0]   status;

    assign req = i_wb_cyc && i_wb_stb && !o_wb_ack;

    // ----------------------------------------
    // Access capture and single-cycle ack
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_ack <= 1'b0;
            we_q     <= 1'b0;
        end else begin
            o_wb_ack <= req;
            if (req) we_q <= i_wb_we;
        end
    end

    always_ff @(posedge i_clk) begin
        if (req) begin
            adr_q <= i_wb_adr;
            dat_q <= i_wb_dat;
        end
    end

    // Address decode
    assign imem_hit = adr_q[NB_WB_ADR-1:NB_PC] == WB_IMEM_BASE[NB_WB_ADR-1:NB_PC];
    assign reg_hit  = adr_q[NB_WB_ADR-1:NB_REG_ADDR] == WB_REG_BASE[NB_WB_ADR-1:NB_REG_ADDR];

    // Writes land in the ack cycle, dropped while running
    assign wr_ok          = o_wb_ack && we_q && !i_busy;
    assign o_imem_we      = wr_ok && imem_hit;
    assign o_reg_we       = wr_ok && reg_hit;
    assign o_start        = wr_ok && (adr_q == WB_CTRL_ADR) && dat_q[0];
    assign o_host_addr    = adr_q[NB_REG_ADDR-1:0];
    assign o_host_wr_data = dat_q;

    always_comb begin
        status                              = '0;
        status[STAT_BUSY]                   = i_busy;
        status[STAT_DONE]                   = i_done;
        status[STAT_ILLEGAL]                = i_illegal;
        status[STAT_ZERO]                   = i_zero;
        status[STAT_STEP_LSB +: NB_STEP]    = i_step;
    end

    // Read mux, unmapped words read as zero
    always_comb begin
        if (imem_hit)                     o_wb_dat = i_imem_data;
        else if (reg_hit)                 o_wb_dat = i_reg_data;
        else if (adr_q == WB_STATUS_ADR)  o_wb_dat = status;
        else                              o_wb_dat = '0;
    end

endmodule
